//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Integer data path width
`define XLEN 32

// Architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// Issue buffering between decode and the ALU
`define ISSUE_FIFO_DEPTH 4
`define ID_W 3

`endif

//--- src/isa_pkg.sv
package isa_pkg;

    ////////////////////
    // Major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD    = 7'b0000011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_AUIPC   = 7'b0010111,
        OPC_STORE   = 7'b0100011,
        OPC_OP      = 7'b0110011,
        OPC_LUI     = 7'b0110111,
        OPC_BRANCH  = 7'b1100011,
        OPC_JALR    = 7'b1100111,
        OPC_JAL     = 7'b1101111,
        OPC_SYSTEM  = 7'b1110011
    } opcode_t;

    ////////////////////
    // ALU function codes shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB  = 3'b000,
        F3_SLL      = 3'b001,
        F3_SLT      = 3'b010,
        F3_SLTU     = 3'b011,
        F3_XOR      = 3'b100,
        F3_SRL_SRA  = 3'b101,
        F3_OR       = 3'b110,
        F3_AND      = 3'b111
    } funct3_t;

    // Upper function field values
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // R-type layout, I-type immediate sits in funct7 and rs2
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t funct3;
        logic [4:0] rd;
        opcode_t opcode;
    } rv_instr_t;

endpackage

//--- src/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    ////////////////////
    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Tag carried from issue to writeback
    typedef logic [`ID_W-1:0] issue_id_t;

    ////////////////////
    // Issue packet
    // Operand b is either rs2 data or the decoded immediate
    typedef struct packed {
        alu_op_t op;
        logic [`REG_ADDR_W-1:0] rd;
        issue_id_t id;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
    } alu_issue_t;

endpackage

//--- src/writeback_if.sv
`timescale 1ns/1ps
`include "core_defines.svh"

interface writeback_if
    import core_pkg::*;
();

    logic valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0] data;
    issue_id_t id;

    // Driven by the ALU unit
    modport source (output valid, rd, data, id);

    // Register file and scoreboard
    modport sink (input valid, rd, data, id);

endinterface

//--- src/register_file.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module register_file (
    input logic clk,
    input logic reset,
    input logic [`REG_ADDR_W-1:0] rs1_addr,
    input logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    writeback_if.sink wb
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    ////////////////////
    // Write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    ////////////////////
    // Read ports
    // x0 is forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- src/issue_fifo.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module issue_fifo
    import core_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic push,
    input alu_issue_t push_packet,
    output logic full,
    output logic valid,
    output alu_issue_t packet,
    input logic pop
);

    localparam int DEPTH = `ISSUE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    alu_issue_t entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full = (count == CNT_W'(DEPTH));
    assign valid = (count != '0);
    assign packet = entries[rd_ptr];

    ////////////////////
    // Pointers and occupancy
    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= push_packet;
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) pop |-> valid)
        else $error("issue FIFO popped while empty");

    count_in_range: assert property (@(posedge clk) disable iff (reset) count <= CNT_W'(DEPTH))
        else $error("issue FIFO count above depth");

endmodule

//--- src/alu_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module alu_unit
    import core_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic valid,
    input alu_issue_t packet,
    output logic pop,
    input logic wb_hold,
    writeback_if.source wb
);

    logic [$clog2(`XLEN)-1:0] shamt;
    logic [`XLEN-1:0] result;
    logic wb_valid_q;
    logic [`REG_ADDR_W-1:0] rd_q;
    issue_id_t id_q;
    logic [`XLEN-1:0] data_q;

    assign pop = valid & ~wb_hold;
    assign shamt = packet.b[$clog2(`XLEN)-1:0];

    ////////////////////
    // Execute
    always_comb begin
        result = '0;
        case (packet.op)
            ALU_ADD: result = packet.a + packet.b;
            ALU_SUB: result = packet.a - packet.b;
            ALU_SLL: result = packet.a << shamt;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(packet.a) < $signed(packet.b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, packet.a < packet.b};
            ALU_XOR: result = packet.a ^ packet.b;
            ALU_SRL: result = packet.a >> shamt;
            ALU_SRA: result = $signed(packet.a) >>> shamt;
            ALU_OR: result = packet.a | packet.b;
            ALU_AND: result = packet.a & packet.b;
            default: result = '0;
        endcase
    end

    ////////////////////
    // Writeback stage
    // Hold freezes the stage so a pending result waits for release
    always_ff @(posedge clk) begin
        if (reset)
            wb_valid_q <= 1'b0;
        else if (!wb_hold)
            wb_valid_q <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            data_q <= result;
            rd_q <= packet.rd;
            id_q <= packet.id;
        end
    end

    assign wb.valid = wb_valid_q & ~wb_hold;
    assign wb.rd = rd_q;
    assign wb.data = data_q;
    assign wb.id = id_q;

    known_op: assert property (@(posedge clk) disable iff (reset) valid |-> (packet.op <= ALU_AND))
        else $error("issue packet carries an undefined ALU op");

endmodule

//--- src/decode_issue.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_issue
    import core_pkg::*;
    import isa_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input rv_instr_t instr,
    output logic instr_accept,
    output logic illegal,
    output logic tr_operand_stall,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input logic [`XLEN-1:0] rs1_data,
    input logic [`XLEN-1:0] rs2_data,
    input logic full,
    output logic push,
    output alu_issue_t push_packet,
    writeback_if.sink wb
);

    logic legal;
    logic uses_rs2;
    logic is_shift;
    logic f7_base;
    logic f7_alt;
    alu_op_t base_op;
    alu_op_t op;
    logic [`XLEN-1:0] imm;
    logic [`NUM_REGS-1:0] pending;
    issue_id_t owner [`NUM_REGS];
    issue_id_t next_id;
    logic owner_done;
    logic src_pending;
    logic accept;

    ////////////////////
    // Decode
    assign f7_base = (instr.funct7 == FUNCT7_BASE);
    assign f7_alt = (instr.funct7 == FUNCT7_ALT);
    assign is_shift = (instr.funct3 == F3_SLL) || (instr.funct3 == F3_SRL_SRA);

    always_comb begin
        base_op = ALU_ADD;
        case (instr.funct3)
            F3_ADD_SUB: base_op = ALU_ADD;
            F3_SLL: base_op = ALU_SLL;
            F3_SLT: base_op = ALU_SLT;
            F3_SLTU: base_op = ALU_SLTU;
            F3_XOR: base_op = ALU_XOR;
            F3_SRL_SRA: base_op = ALU_SRL;
            F3_OR: base_op = ALU_OR;
            F3_AND: base_op = ALU_AND;
        endcase
    end

    always_comb begin
        legal = 1'b0;
        uses_rs2 = 1'b0;
        op = base_op;
        if (instr.opcode == OPC_OP) begin
            uses_rs2 = 1'b1;
            if (f7_base) begin
                legal = 1'b1;
            end else if (f7_alt && (instr.funct3 == F3_ADD_SUB)) begin
                legal = 1'b1;
                op = ALU_SUB;
            end else if (f7_alt && (instr.funct3 == F3_SRL_SRA)) begin
                legal = 1'b1;
                op = ALU_SRA;
            end
        end else if (instr.opcode == OPC_OP_IMM) begin
            // Only shifts constrain the upper immediate bits
            if (instr.funct3 == F3_SLL) begin
                legal = f7_base;
            end else if (instr.funct3 == F3_SRL_SRA) begin
                legal = f7_base | f7_alt;
                op = f7_alt ? ALU_SRA : ALU_SRL;
            end else begin
                legal = 1'b1;
            end
        end
    end

    // Shift amount or sign-extended I-type immediate
    assign imm = is_shift ? {{(`XLEN-`REG_ADDR_W){1'b0}}, instr.rs2}
                          : {{(`XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};

    ////////////////////
    // Operand read and issue decision
    assign rs1_addr = instr.rs1;
    assign rs2_addr = instr.rs2;

    assign src_pending = pending[instr.rs1] | (uses_rs2 & pending[instr.rs2]);
    assign accept = instr_valid & ~full & (~legal | ~src_pending);

    assign instr_accept = accept;
    assign push = accept & legal;
    assign illegal = accept & ~legal;
    assign tr_operand_stall = instr_valid & legal & src_pending;

    always_comb begin
        push_packet.op = op;
        push_packet.rd = instr.rd;
        push_packet.id = next_id;
        push_packet.a = rs1_data;
        push_packet.b = uses_rs2 ? rs2_data : imm;
    end

    ////////////////////
    // Scoreboard and ID counter
    // Only the newest writer of rd releases it
    assign owner_done = wb.valid && (owner[wb.rd] == wb.id);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            next_id <= '0;
        end else begin
            if (owner_done)
                pending[wb.rd] <= 1'b0;
            // New owner of rd overrides a same-cycle clear
            if (push && (instr.rd != '0))
                pending[instr.rd] <= 1'b1;
            if (push)
                next_id <= next_id + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            owner[instr.rd] <= next_id;
    end

    wb_has_owner: assert property (@(posedge clk) disable iff (reset)
                                   (wb.valid && (wb.rd != '0)) |-> pending[wb.rd])
        else $error("writeback to a register with no pending owner");

endmodule

//--- src/int_core.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module int_core
    import core_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input logic [31:0] instr,
    output logic instr_accept,
    output logic illegal,
    output logic tr_operand_stall,
    input logic wb_hold,
    output logic wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic [`ID_W-1:0] wb_id
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic push;
    logic full;
    logic fifo_valid;
    logic pop;
    alu_issue_t push_packet;
    alu_issue_t fifo_packet;

    writeback_if wb_bus ();

    ////////////////////
    // Decode and issue
    decode_issue decode_issue_block (
        .clk (clk),
        .reset (reset),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_accept (instr_accept),
        .illegal (illegal),
        .tr_operand_stall (tr_operand_stall),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .full (full),
        .push (push),
        .push_packet (push_packet),
        .wb (wb_bus)
    );

    issue_fifo issue_fifo_block (
        .clk (clk),
        .reset (reset),
        .push (push),
        .push_packet (push_packet),
        .full (full),
        .valid (fifo_valid),
        .packet (fifo_packet),
        .pop (pop)
    );

    ////////////////////
    // Execute and writeback
    alu_unit alu_unit_block (
        .clk (clk),
        .reset (reset),
        .valid (fifo_valid),
        .packet (fifo_packet),
        .pop (pop),
        .wb_hold (wb_hold),
        .wb (wb_bus)
    );

    register_file register_file_block (
        .clk (clk),
        .reset (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb (wb_bus)
    );

    assign wb_valid = wb_bus.valid;
    assign wb_rd = wb_bus.rd;
    assign wb_data = wb_bus.data;
    assign wb_id = wb_bus.id;

endmodule

//--- verification/int_core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module int_core_tb;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0] data;
        logic [`ID_W-1:0] id;
    } expect_t;

    logic clk;
    logic reset;
    logic instr_valid;
    logic [31:0] instr;
    logic instr_accept;
    logic illegal;
    logic tr_operand_stall;
    logic wb_hold;
    logic wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0] wb_data;
    logic [`ID_W-1:0] wb_id;

    expect_t exp_q[$];
    logic [`XLEN-1:0] model_regs [`NUM_REGS];
    logic [`ID_W-1:0] model_id;
    int accepted_count;
    int stall_count;
    logic hold_en;

    int_core i_int_core (
        .clk (clk),
        .reset (reset),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_accept (instr_accept),
        .illegal (illegal),
        .tr_operand_stall (tr_operand_stall),
        .wb_hold (wb_hold),
        .wb_valid (wb_valid),
        .wb_rd (wb_rd),
        .wb_data (wb_data),
        .wb_id (wb_id)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Reference model
    function automatic logic is_alu_instr(input logic [31:0] word);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = word[31:25];
        f3 = word[14:12];
        if (word[6:0] == 7'b0110011)
            return (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        if (word[6:0] == 7'b0010011) begin
            if (f3 == 3'd1)
                return f7 == 7'h00;
            if (f3 == 3'd5)
                return (f7 == 7'h00) || (f7 == 7'h20);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [31:0] word, input logic [31:0] a,
                                            input logic [31:0] rb);
        logic [31:0] b;
        logic [2:0] f3;
        logic is_op;
        f3 = word[14:12];
        is_op = (word[6:0] == 7'b0110011);
        if (is_op)
            b = rb;
        else if ((f3 == 3'd1) || (f3 == 3'd5))
            b = {27'd0, word[24:20]};
        else
            b = {{20{word[31]}}, word[31:20]};
        case (f3)
            3'd0: return (is_op && word[30]) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return word[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    ////////////////////
    // Instruction generators
    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] random_alu_instr();
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        f3 = 3'($urandom);
        imm = 12'($urandom);
        if ($urandom % 2 == 0) begin
            f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom % 2 == 0)) ? 7'h20 : 7'h00;
            return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'b0110011};
        end
        if (f3 == 3'd1)
            imm[11:5] = 7'h00;
        else if (f3 == 3'd5)
            imm[11:5] = ($urandom % 2 == 0) ? 7'h20 : 7'h00;
        return {imm, 5'($urandom), f3, 5'($urandom), 7'b0010011};
    endfunction

    function automatic logic [31:0] random_other_instr();
        logic [31:0] word;
        word = $urandom;
        case ($urandom % 4)
            0: word[6:0] = 7'b0000011;
            1: word[6:0] = 7'b0100011;
            2: word[6:0] = 7'b1100011;
            // Multiply encoding in the OP space
            default: begin
                word[6:0] = 7'b0110011;
                word[31:25] = 7'h01;
            end
        endcase
        return word;
    endfunction

    // Hold the instruction until the monitor sees it accepted
    task automatic send_instr(input logic [31:0] word);
        int start;
        int waited;
        start = accepted_count;
        waited = 0;
        instr_valid <= 1'b1;
        instr <= word;
        while ((accepted_count == start) && (waited < 300)) begin
            @(posedge clk);
            waited++;
        end
        if (accepted_count == start)
            fail_now("Instruction was never accepted");
    endtask

    task automatic go_idle();
        instr_valid <= 1'b0;
        @(posedge clk);
    endtask

    ////////////////////
    // Monitor and comparison
    always @(negedge clk) begin
        expect_t exp_item;
        logic [31:0] data;
        if (!reset) begin
            if (tr_operand_stall)
                stall_count++;
            assert (!(wb_hold && wb_valid))
                else fail_now($sformatf("Fail wb_valid: got %h expected %h during hold",
                                        wb_valid, 1'b0));
            // Five outstanding means FIFO plus writeback stage are occupied
            if (exp_q.size() >= `ISSUE_FIFO_DEPTH + 1)
                assert (!instr_accept)
                    else fail_now($sformatf("Fail instr_accept: got %h expected %h",
                                            instr_accept, 1'b0));
            assert (instr_valid || !instr_accept)
                else fail_now("Instruction accepted without a valid request");
            if (wb_valid) begin
                assert (exp_q.size() != 0)
                    else fail_now("Writeback with no instruction outstanding");
                exp_item = exp_q.pop_front();
                assert (wb_rd == exp_item.rd)
                    else fail_now($sformatf("Fail wb_rd: got %h expected %h",
                                            wb_rd, exp_item.rd));
                assert (wb_data == exp_item.data)
                    else fail_now($sformatf("Fail wb_data: got %h expected %h",
                                            wb_data, exp_item.data));
                assert (wb_id == exp_item.id)
                    else fail_now($sformatf("Fail wb_id: got %h expected %h",
                                            wb_id, exp_item.id));
            end
            if (instr_valid && instr_accept) begin
                assert (illegal == !is_alu_instr(instr))
                    else fail_now($sformatf("Fail illegal: got %h expected %h",
                                            illegal, !is_alu_instr(instr)));
                if (is_alu_instr(instr)) begin
                    data = ref_alu(instr, model_regs[instr[19:15]], model_regs[instr[24:20]]);
                    exp_q.push_back('{rd: instr[11:7], data: data, id: model_id});
                    if (instr[11:7] != 5'd0)
                        model_regs[instr[11:7]] = data;
                    model_id = model_id + 1'b1;
                end
                accepted_count++;
            end
        end
    end

    always @(posedge clk) begin
        if (hold_en)
            wb_hold <= ($urandom % 3 == 0);
        else
            wb_hold <= 1'b0;
    end

    ////////////////////
    // Test sequence
    initial begin
        int waited;
        int stalls_before;
        void'($urandom(32'hfc95_34d5));
        clk = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        wb_hold = 1'b0;
        hold_en = 1'b0;
        model_id = '0;
        accepted_count = 0;
        stall_count = 0;
        for (int i = 0; i < `NUM_REGS; i++)
            model_regs[i] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Fill registers, negative values included
        for (int r = 1; r < `NUM_REGS; r++)
            send_instr(encode_addi(5'(r), 5'd0, 12'($urandom)));

        // Random mix with other opcodes
        for (int n = 0; n < 250; n++) begin
            if ($urandom % 8 == 0)
                send_instr(random_other_instr());
            else
                send_instr(random_alu_instr());
        end

        // Dependent chain through x5
        stalls_before = stall_count;
        for (int n = 0; n < 12; n++)
            send_instr({7'h00, 5'd6, 5'd5, 3'b000, 5'd5, 7'b0110011});
        go_idle();
        assert (stall_count > stalls_before)
            else fail_now("Dependent chain never raised the operand stall");

        // Random writeback hold
        hold_en <= 1'b1;
        for (int n = 0; n < 200; n++) begin
            if ($urandom % 10 == 0)
                send_instr(random_other_instr());
            else
                send_instr(random_alu_instr());
        end

        // x0 destination, then reads of x0
        send_instr(encode_addi(5'd0, 5'd3, 12'h123));
        send_instr({7'h00, 5'd0, 5'd0, 3'b000, 5'd7, 7'b0110011});
        send_instr(encode_addi(5'd8, 5'd0, 12'h7ff));
        go_idle();
        hold_en <= 1'b0;

        waited = 0;
        while ((exp_q.size() != 0) && (waited < 500)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
            fail_now("Outstanding writebacks never arrived");
        repeat (4) @(posedge clk);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
src/isa_pkg.sv
src/core_pkg.sv
src/writeback_if.sv
src/register_file.sv
src/issue_fifo.sv
src/alu_unit.sv
src/decode_issue.sv
src/int_core.sv
verification/int_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= int_core_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
